// ==== rtl/enq_pkg.sv ====
`default_nettype none

package enq_pkg;

    ////////////////////////////////////////
    // queue layout
    ////////////////////////////////////////

    // four network ports plus the cpu queue
    localparam int NUM_QUEUES = 5;
    localparam int CPU_QUEUE  = 4;

    ////////////////////////////////////////
    // metadata layout
    ////////////////////////////////////////

    localparam int TUSER_WIDTH      = 128;
    localparam int SRC_POS          = 16;
    localparam int DST_POS          = 24;
    localparam int DROP_POS         = 32;
    // one-hot, even bits are ports, odd bits are cpu
    localparam int PORT_FIELD_WIDTH = 8;

    // cpu read address, src in upper nibble, dst in lower
    localparam int STATS_ADDR_WIDTH = 8;

    typedef logic [NUM_QUEUES-1:0] queue_mask_t;
    typedef logic [2:0]            queue_idx_t;

endpackage

`default_nettype wire

// ==== rtl/enq_admission.sv ====
`timescale 1ns/1ps
`default_nettype none

module enq_admission import enq_pkg::*;
(
    input  wire                    axis_aclk,
    input  wire                    axis_resetn,

    // packet beats
    input  wire                    s_axis_tvalid,
    input  wire [TUSER_WIDTH-1:0]  s_axis_tuser,
    input  wire                    s_axis_tlast,
    input  wire                    s_axis_tpifo_valid,
    output logic                   s_axis_tready,

    // queue status
    input  wire queue_mask_t       s_axis_buffer_almost_full,
    input  wire queue_mask_t       s_axis_pifo_full,

    // per-queue enables
    output queue_mask_t            m_axis_ctl_pifo_in_en,
    output queue_mask_t            m_axis_ctl_buffer_wr_en,

    // drop event towards the counters
    output logic                   drop_valid,
    output queue_idx_t             drop_src,
    output queue_mask_t            drop_dst_mask
);

    localparam logic [1:0] IDLE    = 2'd0;
    localparam logic [1:0] SOP     = 2'd1;
    localparam logic [1:0] ENQUEUE = 2'd2;
    localparam logic [1:0] DROP    = 2'd3;

    logic [1:0]                  state;
    logic [1:0]                  state_next;
    logic                        tready_next;
    queue_mask_t                 pifo_en_next;
    queue_mask_t                 wr_en_next;

    logic [PORT_FIELD_WIDTH-1:0] src_field;
    logic [PORT_FIELD_WIDTH-1:0] dst_field;
    queue_mask_t                 dst_mask;
    queue_mask_t                 eligible;
    logic                        drop_cond;
    logic                        last_beat;

    assign src_field = s_axis_tuser[SRC_POS +: PORT_FIELD_WIDTH];
    assign dst_field = s_axis_tuser[DST_POS +: PORT_FIELD_WIDTH];

    ////////////////////////////////////////
    // destination and source decode
    ////////////////////////////////////////

    // even bits map to port queues, any odd bit to the cpu queue
    always_comb
    begin
        dst_mask = '0;
        for (int q = 0; q < CPU_QUEUE; q++)
        begin
            dst_mask[q]         = dst_field[2*q];
            dst_mask[CPU_QUEUE] = dst_mask[CPU_QUEUE] | dst_field[2*q+1];
        end
    end

    always_comb
    begin
        case (src_field)
            8'h01:   drop_src = 3'd0;
            8'h04:   drop_src = 3'd1;
            8'h10:   drop_src = 3'd2;
            8'h40:   drop_src = 3'd3;
            default: drop_src = queue_idx_t'(CPU_QUEUE);
        endcase
    end

    // queues with room in both buffer and rank queue
    assign eligible  = dst_mask & ~s_axis_buffer_almost_full & ~s_axis_pifo_full;
    assign drop_cond = s_axis_tuser[DROP_POS] | ~s_axis_tpifo_valid | ~(|eligible);
    assign last_beat = s_axis_tvalid & s_axis_tready & s_axis_tlast;

    // strobe fires in the idle cycle that decides to drop
    assign drop_valid    = (state == IDLE) & s_axis_tvalid & drop_cond;
    assign drop_dst_mask = dst_mask;

    ////////////////////////////////////////
    // admission fsm
    ////////////////////////////////////////

    always_comb
    begin
        state_next   = state;
        tready_next  = 1'b0;
        pifo_en_next = '0;
        wr_en_next   = m_axis_ctl_buffer_wr_en;

        case (state)
            IDLE:
            begin
                wr_en_next = '0;
                if (s_axis_tvalid)
                begin
                    tready_next = 1'b1;
                    state_next  = drop_cond ? DROP : SOP;
                end
            end
            SOP:
            begin
                // single insert into the rank queue per packet
                pifo_en_next = eligible;
                wr_en_next   = eligible;
                tready_next  = ~last_beat;
                state_next   = last_beat ? IDLE : ENQUEUE;
            end
            default:
            begin
                // ENQUEUE and DROP both run to the end of packet
                tready_next = ~last_beat;
                if (last_beat)
                begin
                    state_next = IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state                   <= IDLE;
            s_axis_tready           <= 1'b0;
            m_axis_ctl_pifo_in_en   <= '0;
            m_axis_ctl_buffer_wr_en <= '0;
        end
        else
        begin
            state                   <= state_next;
            s_axis_tready           <= tready_next;
            m_axis_ctl_pifo_in_en   <= pifo_en_next;
            m_axis_ctl_buffer_wr_en <= wr_en_next;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/drop_count_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module drop_count_table import enq_pkg::*;
#(
    parameter int COUNT_WIDTH = 32
)
(
    input  wire                    axis_aclk,
    input  wire                    axis_resetn,

    // drop event
    input  wire                    drop_valid,
    input  wire queue_idx_t        drop_src,
    input  wire queue_mask_t       drop_dst_mask,

    // read port
    input  wire queue_idx_t        rd_src,
    input  wire queue_idx_t        rd_dst,
    output logic [COUNT_WIDTH-1:0] rd_count
);

    // counts[src][dst]
    logic [COUNT_WIDTH-1:0] counts [NUM_QUEUES][NUM_QUEUES];

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            for (int s = 0; s < NUM_QUEUES; s++)
            begin
                for (int d = 0; d < NUM_QUEUES; d++)
                begin
                    counts[s][d] <= '0;
                end
            end
        end
        else if (drop_valid)
        begin
            // one increment per destination of the dropped packet, wraps
            for (int d = 0; d < NUM_QUEUES; d++)
            begin
                if (drop_dst_mask[d])
                begin
                    counts[drop_src][d] <= counts[drop_src][d] + COUNT_WIDTH'(1);
                end
            end
        end
    end

    assign rd_count = counts[rd_src][rd_dst];

endmodule

`default_nettype wire

// ==== rtl/drop_stats_reader.sv ====
`timescale 1ns/1ps
`default_nettype none

module drop_stats_reader import enq_pkg::*;
#(
    parameter int COUNT_WIDTH = 32
)
(
    input  wire                        axis_aclk,
    input  wire                        axis_resetn,

    // cpu request
    input  wire                        s_axi_req_valid,
    input  wire [STATS_ADDR_WIDTH-1:0] s_axi_addr,

    // counter table lookup
    input  wire [COUNT_WIDTH-1:0]      rd_count,
    output queue_idx_t                 rd_src,
    output queue_idx_t                 rd_dst,

    // cpu response
    output logic [COUNT_WIDTH-1:0]     m_axi_data,
    output logic                       m_axi_resp_valid
);

    localparam logic [3:0] CPU_NIBBLE = 4'(CPU_QUEUE);

    logic [3:0] addr_src;
    logic [3:0] addr_dst;
    logic       src_in_range;

    assign addr_src = s_axi_addr[STATS_ADDR_WIDTH-1 -: 4];
    assign addr_dst = s_axi_addr[3:0];

    assign src_in_range = (addr_src <= CPU_NIBBLE);

    // out of range dst reads the cpu column, out of range src reads zero
    assign rd_dst = (addr_dst > CPU_NIBBLE) ? queue_idx_t'(CPU_QUEUE) : addr_dst[2:0];
    assign rd_src = src_in_range ? addr_src[2:0] : queue_idx_t'(CPU_QUEUE);

    always_ff @(posedge axis_aclk)
    begin
        if (s_axi_req_valid)
        begin
            m_axi_data <= src_in_range ? rd_count : '0;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            m_axi_resp_valid <= 1'b0;
        end
        else
        begin
            m_axi_resp_valid <= s_axi_req_valid;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/enqueue_agent.sv ====
`timescale 1ns/1ps
`default_nettype none

module enqueue_agent import enq_pkg::*;
#(
    parameter int COUNT_WIDTH = 32
)
(
    input  wire                        axis_aclk,
    input  wire                        axis_resetn,

    // packet beats from the pipeline
    input  wire                        s_axis_tvalid,
    input  wire [TUSER_WIDTH-1:0]      s_axis_tuser,
    input  wire                        s_axis_tlast,
    input  wire                        s_axis_tpifo_valid,
    output logic                       s_axis_tready,

    // per-queue status
    input  wire queue_mask_t           s_axis_buffer_almost_full,
    input  wire queue_mask_t           s_axis_pifo_full,

    // per-queue enables
    output queue_mask_t                m_axis_ctl_pifo_in_en,
    output queue_mask_t                m_axis_ctl_buffer_wr_en,

    // cpu drop count reads
    input  wire                        s_axi_req_valid,
    input  wire [STATS_ADDR_WIDTH-1:0] s_axi_addr,
    output logic [COUNT_WIDTH-1:0]     m_axi_data,
    output logic                       m_axi_resp_valid
);

    logic                   drop_valid;
    queue_idx_t             drop_src;
    queue_mask_t            drop_dst_mask;
    queue_idx_t             rd_src;
    queue_idx_t             rd_dst;
    logic [COUNT_WIDTH-1:0] rd_count;

    enq_admission i_enq_admission (
        .axis_aclk                 (axis_aclk),
        .axis_resetn               (axis_resetn),
        .s_axis_tvalid             (s_axis_tvalid),
        .s_axis_tuser              (s_axis_tuser),
        .s_axis_tlast              (s_axis_tlast),
        .s_axis_tpifo_valid        (s_axis_tpifo_valid),
        .s_axis_tready             (s_axis_tready),
        .s_axis_buffer_almost_full (s_axis_buffer_almost_full),
        .s_axis_pifo_full          (s_axis_pifo_full),
        .m_axis_ctl_pifo_in_en     (m_axis_ctl_pifo_in_en),
        .m_axis_ctl_buffer_wr_en   (m_axis_ctl_buffer_wr_en),
        .drop_valid                (drop_valid),
        .drop_src                  (drop_src),
        .drop_dst_mask             (drop_dst_mask)
    );

    drop_count_table #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_drop_count_table (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .drop_valid    (drop_valid),
        .drop_src      (drop_src),
        .drop_dst_mask (drop_dst_mask),
        .rd_src        (rd_src),
        .rd_dst        (rd_dst),
        .rd_count      (rd_count)
    );

    drop_stats_reader #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) i_drop_stats_reader (
        .axis_aclk        (axis_aclk),
        .axis_resetn      (axis_resetn),
        .s_axi_req_valid  (s_axi_req_valid),
        .s_axi_addr       (s_axi_addr),
        .rd_count         (rd_count),
        .rd_src           (rd_src),
        .rd_dst           (rd_dst),
        .m_axi_data       (m_axi_data),
        .m_axi_resp_valid (m_axi_resp_valid)
    );

endmodule

`default_nettype wire

// ==== tests/enqueue_agent_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module enqueue_agent_props import enq_pkg::*;
(
    input wire              axis_aclk,
    input wire              axis_resetn,
    input wire              s_axis_tready,
    input wire queue_mask_t m_axis_ctl_pifo_in_en,
    input wire queue_mask_t m_axis_ctl_buffer_wr_en
);

    // rank insert only alongside a buffer write
    pifo_within_wr: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (m_axis_ctl_pifo_in_en & ~m_axis_ctl_buffer_wr_en) == '0)
        else $error("pifo_in_en set for a queue without buffer_wr_en");

    pifo_single_cycle: assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        (m_axis_ctl_pifo_in_en != '0) |=> (m_axis_ctl_pifo_in_en == '0))
        else $error("pifo_in_en high for two cycles in a row");

    // outputs quiet straight out of reset
    outputs_after_reset: assert property (@(posedge axis_aclk)
        !axis_resetn |=> (!s_axis_tready && m_axis_ctl_pifo_in_en == '0
                          && m_axis_ctl_buffer_wr_en == '0))
        else $error("control outputs not cleared by reset");

endmodule

bind enqueue_agent enqueue_agent_props i_enqueue_agent_props (
    .axis_aclk               (axis_aclk),
    .axis_resetn             (axis_resetn),
    .s_axis_tready           (s_axis_tready),
    .m_axis_ctl_pifo_in_en   (m_axis_ctl_pifo_in_en),
    .m_axis_ctl_buffer_wr_en (m_axis_ctl_buffer_wr_en)
);

`default_nettype wire

// ==== tests/enqueue_agent_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module enqueue_agent_tb import enq_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int NUM_MULTICAST   = 40;
    localparam int NUM_DROPPED     = 8;
    localparam int NUM_ALL_FULL    = 6;
    localparam int NUM_PACKETS     = 4 + NUM_MULTICAST + NUM_DROPPED + NUM_ALL_FULL;
    localparam int WATCHDOG_CYCLES = NUM_PACKETS * 10 + 200;

    logic                        axis_aclk;
    logic                        axis_resetn;
    logic                        s_axis_tvalid;
    logic [TUSER_WIDTH-1:0]      s_axis_tuser;
    logic                        s_axis_tlast;
    logic                        s_axis_tpifo_valid;
    logic                        s_axis_tready;
    queue_mask_t                 almost_full;
    queue_mask_t                 pifo_full;
    queue_mask_t                 pifo_in_en;
    queue_mask_t                 buffer_wr_en;
    logic                        s_axi_req_valid;
    logic [STATS_ADDR_WIDTH-1:0] s_axi_addr;
    logic [31:0]                 m_axi_data;
    logic                        m_axi_resp_valid;

    logic [31:0] rng = 32'h8215_69f0;
    queue_mask_t exp_mask = '0;
    int          pifo_pulses = 0;
    int          wr_cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int unsigned model_counts [NUM_QUEUES][NUM_QUEUES];

    enqueue_agent #(
        .COUNT_WIDTH (32)
    ) i_enqueue_agent (
        .axis_aclk                 (axis_aclk),
        .axis_resetn               (axis_resetn),
        .s_axis_tvalid             (s_axis_tvalid),
        .s_axis_tuser              (s_axis_tuser),
        .s_axis_tlast              (s_axis_tlast),
        .s_axis_tpifo_valid        (s_axis_tpifo_valid),
        .s_axis_tready             (s_axis_tready),
        .s_axis_buffer_almost_full (almost_full),
        .s_axis_pifo_full          (pifo_full),
        .m_axis_ctl_pifo_in_en     (pifo_in_en),
        .m_axis_ctl_buffer_wr_en   (buffer_wr_en),
        .s_axi_req_valid           (s_axi_req_valid),
        .s_axi_addr                (s_axi_addr),
        .m_axi_data                (m_axi_data),
        .m_axi_resp_valid          (m_axi_resp_valid)
    );

    always #(CLK_PERIOD / 2) axis_aclk = ~axis_aclk;

    ////////////////////////////////////////
    // reference model
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // even bit 2q is port q, any odd bit is the cpu queue
    function automatic queue_mask_t dest_mask(input logic [7:0] field);
        queue_mask_t m;
        m = '0;
        for (int b = 0; b < 8; b++)
        begin
            if (field[b] && (b % 2 == 0))
                m[b / 2] = 1'b1;
            else if (field[b])
                m[CPU_QUEUE] = 1'b1;
        end
        return m;
    endfunction

    function automatic int src_index(input logic [7:0] field);
        case (field)
            8'h01:   return 0;
            8'h04:   return 1;
            8'h10:   return 2;
            8'h40:   return 3;
            default: return CPU_QUEUE;
        endcase
    endfunction

    // zero means the packet is dropped
    function automatic queue_mask_t expected_mask(input logic [TUSER_WIDTH-1:0] tuser,
        input logic pifo_valid, input queue_mask_t af, input queue_mask_t pf);
        queue_mask_t elig;
        elig = dest_mask(tuser[DST_POS +: PORT_FIELD_WIDTH]) & ~af & ~pf;
        if (tuser[DROP_POS] || !pifo_valid || elig == '0)
            return '0;
        return elig;
    endfunction

    function automatic logic [TUSER_WIDTH-1:0] make_tuser(input logic [31:0] filler,
        input logic [7:0] src, input logic [7:0] dst, input logic drop);
        logic [TUSER_WIDTH-1:0] t;
        t = {4{filler}};
        t[SRC_POS +: PORT_FIELD_WIDTH] = src;
        t[DST_POS +: PORT_FIELD_WIDTH] = dst;
        t[DROP_POS] = drop;
        return t;
    endfunction

    // mostly valid one-hot sources, sometimes arbitrary fields
    function automatic logic [7:0] random_source(input logic [31:0] w);
        return w[3] ? (8'h01 << (2 * w[1:0])) : w[11:4];
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
        input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error at time %0t: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    task automatic send_packet(input logic [TUSER_WIDTH-1:0] tuser, input logic pifo_valid,
        input int n, input queue_mask_t af, input queue_mask_t pf);
        int          beats;
        int          cycles;
        bit          done;
        int          src;
        queue_mask_t dst;
        beats       = 0;
        cycles      = 0;
        done        = 1'b0;
        src         = src_index(tuser[SRC_POS +: PORT_FIELD_WIDTH]);
        dst         = dest_mask(tuser[DST_POS +: PORT_FIELD_WIDTH]);
        exp_mask    = expected_mask(tuser, pifo_valid, af, pf);
        pifo_pulses = 0;
        wr_cycles   = 0;
        // a drop counts once per destination, full or not
        for (int d = 0; d < NUM_QUEUES; d++)
        begin
            if (exp_mask == '0 && dst[d])
                model_counts[src][d] += 1;
        end
        s_axis_tuser       = tuser;
        s_axis_tpifo_valid = pifo_valid;
        almost_full        = af;
        pifo_full          = pf;
        s_axis_tvalid      = 1'b1;
        s_axis_tlast       = (n == 1);
        while (!done)
        begin
            @(negedge axis_aclk);
            cycles++;
            if (s_axis_tready)
            begin
                beats++;
                done = s_axis_tlast;
            end
            @(posedge axis_aclk);
            #1;
            s_axis_tlast = (beats == n - 1);
        end
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
        @(negedge axis_aclk);
        check_value("s_axis_tready", 32'(s_axis_tready), 32'd0);
        @(negedge axis_aclk);
        check_value("m_axis_ctl_buffer_wr_en", 32'(buffer_wr_en), 32'd0);
        @(posedge axis_aclk);
        #1;
        check_value("pifo_in_en pulse count", pifo_pulses, (exp_mask == '0) ? 0 : 1);
        check_value("buffer_wr_en cycle count", wr_cycles, (exp_mask == '0) ? 0 : n);
        // one idle cycle, then a beat accepted in every cycle
        check_value("cycles to accept packet", cycles, n + 1);
    endtask

    task automatic cpu_read(input logic [7:0] addr);
        logic [31:0] expected;
        int          s;
        int          d;
        s = int'(addr[7:4]);
        d = (int'(addr[3:0]) > CPU_QUEUE) ? CPU_QUEUE : int'(addr[3:0]);
        expected = (s > CPU_QUEUE) ? 32'd0 : model_counts[s][d];
        s_axi_req_valid = 1'b1;
        s_axi_addr      = addr;
        @(posedge axis_aclk);
        #1;
        s_axi_req_valid = 1'b0;
        @(negedge axis_aclk);
        check_value("m_axi_resp_valid", 32'(m_axi_resp_valid), 32'd1);
        check_value("m_axi_data", m_axi_data, expected);
        @(posedge axis_aclk);
        #1;
    endtask

    task automatic report_test(input int num, input string name, input int start);
        $display("test %0d %s: %0d errors", num, name, errors - start);
    endtask

    // masks are compared whenever the DUT raises them
    always @(negedge axis_aclk)
    begin
        if (axis_resetn && pifo_in_en != '0)
        begin
            pifo_pulses++;
            check_value("m_axis_ctl_pifo_in_en", 32'(pifo_in_en), 32'(exp_mask));
        end
        if (axis_resetn && buffer_wr_en != '0)
        begin
            wr_cycles++;
            check_value("m_axis_ctl_buffer_wr_en", 32'(buffer_wr_en), 32'(exp_mask));
        end
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("run timed out after %0d cycles without finishing", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        int          start;
        int          len;
        logic [7:0]  dst;
        queue_mask_t af;
        queue_mask_t pf;
        axis_aclk          = 1'b0;
        axis_resetn        = 1'b0;
        s_axis_tvalid      = 1'b0;
        s_axis_tuser       = '0;
        s_axis_tlast       = 1'b0;
        s_axis_tpifo_valid = 1'b0;
        almost_full        = '0;
        pifo_full          = '0;
        s_axi_req_valid    = 1'b0;
        s_axi_addr         = '0;
        for (int s = 0; s < NUM_QUEUES; s++)
        begin
            for (int d = 0; d < NUM_QUEUES; d++)
                model_counts[s][d] = 0;
        end
        repeat (2) @(posedge axis_aclk);
        #1;
        axis_resetn = 1'b1;

        start = errors;
        for (int q = 0; q < CPU_QUEUE; q++)
        begin
            rng = xorshift(rng);
            len = int'(rng % 32'd6) + 1;
            send_packet(make_tuser(rng, random_source(rng), 8'h01 << (2 * q), 1'b0),
                        1'b1, len, '0, '0);
        end
        report_test(1, "unicast to each port", start);

        start = errors;
        for (int i = 0; i < NUM_MULTICAST; i++)
        begin
            rng = xorshift(rng);
            dst = (rng[7:0] == 8'h00) ? 8'h01 : rng[7:0];
            af  = rng[12:8] & rng[17:13];
            pf  = rng[22:18] & rng[27:23];
            rng = xorshift(rng);
            len = int'(rng % 32'd6) + 1;
            send_packet(make_tuser(rng, random_source(rng), dst, 1'b0), 1'b1, len, af, pf);
        end
        report_test(2, "random multicast", start);

        ////////////////////////////////////////
        // drop paths and stats readback
        ////////////////////////////////////////

        start = errors;
        for (int i = 0; i < NUM_DROPPED; i++)
        begin
            rng = xorshift(rng);
            dst = rng[7:0] | 8'h01;
            len = int'(rng % 32'd6) + 1;
            // even packets carry the drop flag, odd ones an invalid rank entry
            send_packet(make_tuser(rng, random_source(rng), dst, (i % 2 == 0)),
                        (i % 2 == 0), len, '0, '0);
        end
        report_test(3, "drop flag and invalid rank", start);

        start = errors;
        for (int i = 0; i < NUM_ALL_FULL; i++)
        begin
            rng = xorshift(rng);
            dst = rng[23:16] | 8'h10;
            af  = dest_mask(dst) & queue_mask_t'(rng[4:0]);
            pf  = dest_mask(dst) & ~af;
            len = int'(rng % 32'd6) + 1;
            send_packet(make_tuser(rng, (i % 2 == 0) ? (8'h80 | rng[15:8]) : random_source(rng),
                                   dst, 1'b0), 1'b1, len, af, pf);
        end
        report_test(4, "all destinations full", start);

        start = errors;
        for (int s = 0; s < NUM_QUEUES; s++)
        begin
            for (int d = 0; d < NUM_QUEUES; d++)
                cpu_read({4'(s), 4'(d)});
        end
        cpu_read(8'h72);
        cpu_read(8'h3c);
        report_test(5, "cpu count reads", start);

        $display("5 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("TB PASSED");
        end
        else
        begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/enq_pkg.sv
rtl/enq_admission.sv
rtl/drop_count_table.sv
rtl/drop_stats_reader.sv
rtl/enqueue_agent.sv
tests/enqueue_agent_props.sv
tests/enqueue_agent_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the enqueue agent testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module enqueue_agent_tb \
    -f verilog.f \
    -o enqueue_agent_sim

./obj_dir/enqueue_agent_sim 2>&1 | tee sim.log

# the log decides the result
grep -q "TB PASSED" sim.log
echo "simulation log search found the pass message"
